/* hw/issue_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage sizes, enums and row/issue structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package issue_pkg;

    localparam int NUM_FU = 3;   // alu, load/store, branch
    localparam int AGE_W  = 4;
    localparam int REG_W  = 5;
    localparam int WORD_W = 32;

    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_LDST   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_e;

    typedef enum logic [1:0] {
        FUST_EMPTY,
        FUST_WAIT,   // holding, tags may still be pending
        FUST_RDY,    // ready but lost selection
        FUST_EX
    } fust_state_e;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5,
        BEQ = 4'd6,
        BNE = 4'd7
    } alu_op_e;

    typedef struct packed {
        alu_op_e            op;
        logic [REG_W-1:0]   rd;
        logic [REG_W-1:0]   rs1;
        logic [REG_W-1:0]   rs2;
        logic [WORD_W-1:0]  imm;
        logic               i_type;
        logic               spec;
        logic [REG_W-1:0]   t1;   // 0 means no dependency
        logic [REG_W-1:0]   t2;
    } fust_row_t;

    typedef struct packed {
        logic [NUM_FU-1:0]  fu_en;
        alu_op_e            op;
        logic [REG_W-1:0]   rd;
        logic [WORD_W-1:0]  rdat1;
        logic [WORD_W-1:0]  rdat2;
        logic [WORD_W-1:0]  imm;
        logic               spec;
    } issue_t;

endpackage

/* hw/fust_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// status table to select logic interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface fust_if import issue_pkg::*; ();

    fust_row_t   [NUM_FU-1:0] rows;
    logic        [NUM_FU-1:0] tags_clear;   // both source tags are zero
    fust_state_e [NUM_FU-1:0] state;
    logic        [NUM_FU-1:0] flush_mask;   // rows emptied at the next edge

    // table side
    modport tbl (
        output rows,
        output tags_clear,
        input  state,
        input  flush_mask
    );

    // select side
    modport sel (
        input  rows,
        input  tags_clear,
        output state,
        output flush_mask
    );

endinterface

/* hw/regfile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32x32 register file, 2 read / 1 write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module regfile import issue_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              wen,
    input  logic [REG_W-1:0]  wsel,
    input  logic [WORD_W-1:0] wdata,
    input  logic [REG_W-1:0]  rsel1,
    input  logic [REG_W-1:0]  rsel2,
    output logic [WORD_W-1:0] rdat1,
    output logic [WORD_W-1:0] rdat2
);

    logic [WORD_W-1:0] regs [2**REG_W];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            regs <= '{default: '0};
        end else if (wen && (wsel != '0)) begin   // r0 never written
            regs[wsel] <= wdata;
        end
    end

    always_comb begin
        if (rsel1 == '0) begin
            rdat1 = '0;
        end else if (wen && (wsel == rsel1)) begin
            rdat1 = wdata;   // forward same-cycle write
        end else begin
            rdat1 = regs[rsel1];
        end

        if (rsel2 == '0) begin
            rdat2 = '0;
        end else if (wen && (wsel == rsel2)) begin
            rdat2 = wdata;
        end else begin
            rdat2 = regs[rsel2];
        end
    end

endmodule

/* hw/fust.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scalar FUST rows with writeback tag wakeup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fust import issue_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              disp_en,
    input  fu_e               disp_fu,
    input  fust_row_t         disp_row,
    input  logic              wb_en,
    input  logic [REG_W-1:0]  wb_sel,
    fust_if.tbl               fi
);

    fust_row_t [NUM_FU-1:0] rows_q;

    // zero any tag that the current writeback resolves
    function automatic fust_row_t wake(input fust_row_t row, input logic en,
                                       input logic [REG_W-1:0] sel);
        fust_row_t r;
        r = row;
        if (en && (r.t1 == sel)) begin
            r.t1 = '0;
        end
        if (en && (r.t2 == sel)) begin
            r.t2 = '0;
        end
        return r;
    endfunction

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rows_q <= '0;
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (fi.flush_mask[i]) begin
                    rows_q[i] <= '0;   // flushed or completed
                end else if (disp_en && (disp_fu == fu_e'(i))) begin
                    rows_q[i] <= wake(disp_row, wb_en, wb_sel);
                end else begin
                    rows_q[i] <= wake(rows_q[i], wb_en, wb_sel);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            fi.tags_clear[i] = (rows_q[i].t1 == '0) && (rows_q[i].t2 == '0);
        end
    end

    assign fi.rows = rows_q;

    // dispatch only writes a row after its credit came back
    a_write_empty_row: assert property (
        @(posedge CLK) disable iff (!nRST)
        disp_en |-> (fi.state[disp_fu] == FUST_EMPTY)
    ) else $error("dispatch write to occupied FUST row %0d", disp_fu);

endmodule

/* hw/issue_select.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// row FSMs, ages and oldest-ready select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module issue_select import issue_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              disp_en,
    input  fu_e               disp_fu,
    input  logic              freeze,
    input  logic [NUM_FU-1:0] fu_done,
    input  logic              branch_miss,
    fust_if.sel               fi,
    output logic [NUM_FU-1:0] issue_sel,
    output logic [NUM_FU-1:0] credit_return
);

    fust_state_e [NUM_FU-1:0]            state_q, state_n;
    logic        [NUM_FU-1:0][AGE_W-1:0] age_q, age_n;
    logic        [NUM_FU-1:0]            cand;
    logic        [NUM_FU-1:0]            release_mask;
    logic        [NUM_FU-1:0]            ex_entry;

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            cand[i] = ((state_q[i] == FUST_WAIT) && fi.tags_clear[i]) ||
                      (state_q[i] == FUST_RDY);
            release_mask[i] = (branch_miss && (state_q[i] != FUST_EMPTY) && fi.rows[i].spec) ||
                              ((state_q[i] == FUST_EX) && fu_done[i]);
        end
    end

    assign fi.flush_mask = release_mask;
    assign fi.state      = state_q;

    // strict compare keeps the lower index on equal ages
    always_comb begin : pick_oldest
        logic             found;
        logic [AGE_W-1:0] best_age;
        found     = 1'b0;
        best_age  = '0;
        issue_sel = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (cand[i] && (!found || (age_q[i] > best_age))) begin
                issue_sel    = '0;
                issue_sel[i] = 1'b1;
                best_age     = age_q[i];
                found        = 1'b1;
            end
        end
        if (freeze || branch_miss) begin
            issue_sel = '0;
        end
    end

    always_comb begin
        state_n = state_q;
        age_n   = age_q;
        for (int i = 0; i < NUM_FU; i++) begin
            case (state_q[i])
                FUST_EMPTY: begin
                    if (disp_en && (disp_fu == fu_e'(i))) begin
                        state_n[i] = FUST_WAIT;
                        age_n[i]   = AGE_W'(1);
                    end
                end
                FUST_WAIT, FUST_RDY: begin
                    if (issue_sel[i]) begin
                        state_n[i] = FUST_EX;
                        age_n[i]   = '0;
                    end else begin
                        if (cand[i]) begin
                            state_n[i] = FUST_RDY;   // ready but lost
                        end
                        if (disp_en && (age_q[i] != '1)) begin
                            age_n[i] = age_q[i] + AGE_W'(1);
                        end
                    end
                end
                default: age_n[i] = '0;   // EX
            endcase
            if (release_mask[i]) begin
                state_n[i] = FUST_EMPTY;
                age_n[i]   = '0;
            end
        end
    end

    // rows moving into EX at the next edge
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            ex_entry[i] = (state_n[i] == FUST_EX) && (state_q[i] != FUST_EX);
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                state_q[i] <= FUST_EMPTY;
            end
            age_q         <= '0;
            credit_return <= '0;
        end else begin
            state_q       <= state_n;
            age_q         <= age_n;
            credit_return <= release_mask;   // one pulse per emptied row
        end
    end

    a_sel_onehot: assert property (
        @(posedge CLK) disable iff (!nRST) $onehot0(ex_entry)
    ) else $error("more than one row entering EX: %b", ex_entry);

    a_freeze_no_issue: assert property (
        @(posedge CLK) disable iff (!nRST) freeze |-> (ex_entry == '0)
    ) else $error("row entering EX while frozen");

endmodule

/* hw/issue_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage top: FUST, select, regfile, output reg
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module issue_stage import issue_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    // dispatch
    input  logic              disp_en,
    input  fu_e               disp_fu,
    input  alu_op_e           disp_op,
    input  logic [REG_W-1:0]  disp_rd,
    input  logic [REG_W-1:0]  disp_rs1,
    input  logic [REG_W-1:0]  disp_rs2,
    input  logic [WORD_W-1:0] disp_imm,
    input  logic              disp_i_type,
    input  logic              disp_spec,
    input  logic [REG_W-1:0]  disp_t1,
    input  logic [REG_W-1:0]  disp_t2,
    input  logic              freeze,
    output logic [NUM_FU-1:0] credit_return,
    // writeback, execute, branch
    input  logic              wb_en,
    input  logic [REG_W-1:0]  wb_sel,
    input  logic [WORD_W-1:0] wb_data,
    input  logic [NUM_FU-1:0] fu_done,
    input  logic              branch_miss,
    // issued operation
    output logic [NUM_FU-1:0] out_fu_en,
    output alu_op_e           out_op,
    output logic [REG_W-1:0]  out_rd,
    output logic [WORD_W-1:0] out_rdat1,
    output logic [WORD_W-1:0] out_rdat2,
    output logic [WORD_W-1:0] out_imm,
    output logic              out_spec
);

    fust_if fi ();

    fust_row_t         disp_row, sel_row;
    logic [NUM_FU-1:0] issue_sel;
    logic [WORD_W-1:0] rf_rdat1, rf_rdat2;
    issue_t            issue_n, issue_q;

    always_comb begin
        disp_row        = '0;
        disp_row.op     = disp_op;
        disp_row.rd     = disp_rd;
        disp_row.rs1    = disp_rs1;
        disp_row.rs2    = disp_rs2;
        disp_row.imm    = disp_imm;
        disp_row.i_type = disp_i_type;
        disp_row.spec   = disp_spec;
        disp_row.t1     = disp_t1;
        disp_row.t2     = disp_t2;
    end

    fust fust_i (
        .CLK(CLK), .nRST(nRST),
        .disp_en(disp_en), .disp_fu(disp_fu), .disp_row(disp_row),
        .wb_en(wb_en), .wb_sel(wb_sel),
        .fi(fi.tbl)
    );

    issue_select select_i (
        .CLK(CLK), .nRST(nRST),
        .disp_en(disp_en), .disp_fu(disp_fu), .freeze(freeze),
        .fu_done(fu_done), .branch_miss(branch_miss),
        .fi(fi.sel),
        .issue_sel(issue_sel), .credit_return(credit_return)
    );

    always_comb begin
        sel_row = '0;   // zero when nothing is picked
        for (int i = 0; i < NUM_FU; i++) begin
            if (issue_sel[i]) begin
                sel_row = fi.rows[i];
            end
        end
    end

    regfile rf_i (
        .CLK(CLK), .nRST(nRST),
        .wen(wb_en), .wsel(wb_sel), .wdata(wb_data),
        .rsel1(sel_row.rs1), .rsel2(sel_row.rs2),
        .rdat1(rf_rdat1), .rdat2(rf_rdat2)
    );

    always_comb begin
        issue_n.fu_en = issue_sel;
        issue_n.op    = sel_row.op;
        issue_n.rd    = sel_row.rd;
        issue_n.rdat1 = rf_rdat1;
        issue_n.rdat2 = (sel_row.i_type && !issue_sel[FU_LDST]) ? sel_row.imm : rf_rdat2;
        issue_n.imm   = sel_row.imm;
        issue_n.spec  = sel_row.spec && !branch_miss;
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            issue_q <= '0;
        end else if (!freeze) begin   // freeze holds everything, fu_en included
            issue_q <= issue_n;
        end
    end

    assign out_fu_en = issue_q.fu_en;
    assign out_op    = issue_q.op;
    assign out_rd    = issue_q.rd;
    assign out_rdat1 = issue_q.rdat1;
    assign out_rdat2 = issue_q.rdat2;
    assign out_imm   = issue_q.imm;
    assign out_spec  = issue_q.spec;

endmodule

/* tb/issue_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output watcher: issued op and credit compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module issue_checker import issue_pkg::*; (
    input  logic              CLK,
    input  logic              chk_en,
    input  logic [63:0]       name,
    input  logic [NUM_FU-1:0] e_en,
    input  alu_op_e           e_op,
    input  logic [REG_W-1:0]  e_rd,
    input  logic [WORD_W-1:0] e_r1,
    input  logic [WORD_W-1:0] e_r2,
    input  logic [WORD_W-1:0] e_imm,
    input  logic              e_spec,
    input  logic [NUM_FU-1:0] e_cr,
    input  logic [NUM_FU-1:0] out_fu_en,
    input  alu_op_e           out_op,
    input  logic [REG_W-1:0]  out_rd,
    input  logic [WORD_W-1:0] out_rdat1,
    input  logic [WORD_W-1:0] out_rdat2,
    input  logic [WORD_W-1:0] out_imm,
    input  logic              out_spec,
    input  logic [NUM_FU-1:0] credit_return,
    output int                errors
);

    int count = 0;

    assign errors = count;

    task automatic compare(input string field, input logic [WORD_W-1:0] exp_v,
                           input logic [WORD_W-1:0] act_v);
        if (exp_v !== act_v) begin
            count++;
            $display("Mismatch %0s %0s: expected %h, actual %h", name, field, exp_v, act_v);
        end
    endtask

    // outputs settle after the rising edge, sample mid cycle
    always @(negedge CLK) begin
        if (chk_en) begin
            compare("fu_en", WORD_W'(e_en), WORD_W'(out_fu_en));
            compare("credit", WORD_W'(e_cr), WORD_W'(credit_return));
            if (e_en != '0) begin   // payload only matters on an issue
                compare("op", WORD_W'(e_op), WORD_W'(out_op));
                compare("rd", WORD_W'(e_rd), WORD_W'(out_rd));
                compare("rdat1", e_r1, out_rdat1);
                compare("rdat2", e_r2, out_rdat2);
                compare("imm", e_imm, out_imm);
                compare("spec", WORD_W'(e_spec), WORD_W'(out_spec));
            end
        end
    end

endmodule

/* tb/issue_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage testbench: table, credits, loop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module issue_tb import issue_pkg::*; ();

    // expectations describe the outputs seen while the row is applied
    typedef struct packed {
        logic [63:0]       name;
        logic              den;
        fu_e               dfu;
        alu_op_e           dop;
        logic [REG_W-1:0]  drd, drs1, drs2;
        logic [WORD_W-1:0] dimm;
        logic              dit, dspec;
        logic [REG_W-1:0]  dt1, dt2;
        logic              wben;
        logic [REG_W-1:0]  wbsel;
        logic [WORD_W-1:0] wbdata;
        logic [NUM_FU-1:0] done;
        logic              frz, bm;
        logic [NUM_FU-1:0] e_en;
        alu_op_e           e_op;
        logic [REG_W-1:0]  e_rd;
        logic [WORD_W-1:0] e_r1, e_r2;
        logic [WORD_W-1:0] e_imm;
        logic              e_spec;
        logic [NUM_FU-1:0] e_cr;
    } stim_t;

    logic CLK, nRST, chk_en;
    stim_t row, cur;
    stim_t tbl [$];
    logic [WORD_W-1:0] regm [32];   // register model
    logic [WORD_W-1:0] imm_a, imm_b, imm_c;
    integer seed = 32'hd4545e3e;
    int credits [NUM_FU];
    int chk_errors, timeouts, credit_faults;

    logic [NUM_FU-1:0] credit_return, out_fu_en;
    alu_op_e           out_op;
    logic [REG_W-1:0]  out_rd;
    logic [WORD_W-1:0] out_rdat1, out_rdat2, out_imm;
    logic              out_spec;

    issue_stage dut_i (
        .CLK(CLK), .nRST(nRST),
        .disp_en(row.den), .disp_fu(row.dfu), .disp_op(row.dop), .disp_rd(row.drd),
        .disp_rs1(row.drs1), .disp_rs2(row.drs2), .disp_imm(row.dimm),
        .disp_i_type(row.dit), .disp_spec(row.dspec), .disp_t1(row.dt1), .disp_t2(row.dt2),
        .freeze(row.frz), .credit_return(credit_return),
        .wb_en(row.wben), .wb_sel(row.wbsel), .wb_data(row.wbdata),
        .fu_done(row.done), .branch_miss(row.bm),
        .out_fu_en(out_fu_en), .out_op(out_op), .out_rd(out_rd), .out_rdat1(out_rdat1),
        .out_rdat2(out_rdat2), .out_imm(out_imm), .out_spec(out_spec)
    );

    issue_checker checker_i (
        .CLK(CLK), .chk_en(chk_en), .name(row.name),
        .e_en(row.e_en), .e_op(row.e_op), .e_rd(row.e_rd), .e_r1(row.e_r1),
        .e_r2(row.e_r2), .e_imm(row.e_imm), .e_spec(row.e_spec), .e_cr(row.e_cr),
        .out_fu_en(out_fu_en), .out_op(out_op), .out_rd(out_rd), .out_rdat1(out_rdat1),
        .out_rdat2(out_rdat2), .out_imm(out_imm), .out_spec(out_spec),
        .credit_return(credit_return), .errors(chk_errors)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(negedge CLK) begin
        if (nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (credit_return[i]) begin
                    credits[i]++;
                end
            end
        end
    end

    task automatic start(input logic [63:0] nm);
        cur = '0;
        cur.name = nm;
    endtask

    task automatic idle_row(input logic [63:0] nm);
        start(nm);
        tbl.push_back(cur);
    endtask

    task automatic credit_row(input logic [63:0] nm, input logic [NUM_FU-1:0] cr);
        start(nm);
        cur.e_cr = cr;
        tbl.push_back(cur);
    endtask

    task automatic disp(input fu_e fu, input alu_op_e op, input logic [REG_W-1:0] rd,
                        input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2,
                        input logic [WORD_W-1:0] imm, input logic it, input logic spec,
                        input logic [REG_W-1:0] t1, input logic [REG_W-1:0] t2);
        cur.den   = 1'b1;
        cur.dfu   = fu;
        cur.dop   = op;
        cur.drd   = rd;
        cur.drs1  = rs1;
        cur.drs2  = rs2;
        cur.dimm  = imm;
        cur.dit   = it;
        cur.dspec = spec;
        cur.dt1   = t1;
        cur.dt2   = t2;
    endtask

    task automatic writeback(input logic [REG_W-1:0] sel);
        cur.wben   = 1'b1;
        cur.wbsel  = sel;
        cur.wbdata = $random(seed);
        regm[sel]  = cur.wbdata;
    endtask

    task automatic expect_issue(input fu_e fu, input alu_op_e op, input logic [REG_W-1:0] rd,
                                input logic [WORD_W-1:0] r1, input logic [WORD_W-1:0] r2,
                                input logic [WORD_W-1:0] imm, input logic spec);
        cur.e_en   = NUM_FU'(1) << fu;
        cur.e_op   = op;
        cur.e_rd   = rd;
        cur.e_r1   = r1;
        cur.e_r2   = r2;
        cur.e_imm  = imm;
        cur.e_spec = spec;
    endtask

    task automatic build_table();
        imm_a = $random(seed);
        imm_b = $random(seed);
        imm_c = $random(seed);
        for (int r = 1; r <= 3; r++) begin
            start("preload ");
            writeback(REG_W'(r));
            tbl.push_back(cur);
        end
        // independent ops, register and immediate operands
        start("indep_rr");
        disp(FU_ALU, ADD, 4, 1, 2, imm_a, 0, 0, 0, 0);
        tbl.push_back(cur);
        idle_row("indep_rr");
        start("indep_rr");
        expect_issue(FU_ALU, ADD, 4, regm[1], regm[2], imm_a, 0);
        cur.done = 3'b001;
        tbl.push_back(cur);
        credit_row("indep_rr", 3'b001);
        start("indep_im");
        disp(FU_ALU, SUB, 5, 3, 0, imm_b, 1, 1, 0, 0);
        tbl.push_back(cur);
        idle_row("indep_im");
        start("indep_im");
        expect_issue(FU_ALU, SUB, 5, regm[3], imm_b, imm_b, 1);
        cur.done = 3'b001;
        tbl.push_back(cur);
        credit_row("indep_im", 3'b001);
        // load/store waits on r7, immediate does not replace rdat2
        start("wakeup  ");
        disp(FU_LDST, ADD, 6, 7, 1, imm_c, 1, 0, 7, 0);
        tbl.push_back(cur);
        idle_row("wakeup  ");
        start("wakeup  ");
        writeback(7);
        tbl.push_back(cur);
        idle_row("wakeup  ");
        start("wakeup  ");
        expect_issue(FU_LDST, ADD, 6, regm[7], regm[1], imm_c, 0);
        cur.done = 3'b010;
        tbl.push_back(cur);
        credit_row("wakeup  ", 3'b010);
        // older ALU row beats the branch row woken together
        start("age_ordr");
        disp(FU_ALU, XOR, 9, 8, 2, 0, 0, 0, 8, 0);
        tbl.push_back(cur);
        start("age_ordr");
        disp(FU_BRANCH, BEQ, 0, 1, 2, 0, 0, 0, 8, 0);
        tbl.push_back(cur);
        start("age_ordr");
        writeback(8);
        tbl.push_back(cur);
        start("age_ordr");
        writeback(2);   // forwarded to the ALU read in this cycle
        tbl.push_back(cur);
        start("age_ordr");
        expect_issue(FU_ALU, XOR, 9, regm[8], regm[2], 0, 0);
        cur.done = 3'b001;
        tbl.push_back(cur);
        start("age_ordr");
        expect_issue(FU_BRANCH, BEQ, 0, regm[1], regm[2], 0, 0);
        cur.e_cr = 3'b001;
        cur.done = 3'b100;
        tbl.push_back(cur);
        credit_row("age_ordr", 3'b100);
        // saturate both ages with flushed branch dispatches
        start("tie_loop");
        disp(FU_ALU, OR, 13, 10, 3, 0, 0, 0, 10, 0);
        tbl.push_back(cur);
        start("tie_loop");
        disp(FU_LDST, AND, 14, 2, 10, 0, 0, 0, 0, 10);
        tbl.push_back(cur);
        for (int k = 0; k < 14; k++) begin
            start("tie_loop");
            disp(FU_BRANCH, BNE, 0, 10, 1, 0, 0, 1, 10, 0);
            tbl.push_back(cur);
            start("tie_loop");
            cur.bm = 1'b1;
            tbl.push_back(cur);
            credit_row("tie_loop", 3'b100);
        end
        start("tie_loop");
        writeback(10);
        tbl.push_back(cur);
        idle_row("tie_loop");
        // freeze holds the ALU issue, LDST waits in RDY
        start("freeze  ");
        expect_issue(FU_ALU, OR, 13, regm[10], regm[3], 0, 0);
        cur.frz = 1'b1;
        cur.done = 3'b001;
        tbl.push_back(cur);
        cur.done = '0;
        cur.e_cr = 3'b001;
        tbl.push_back(cur);
        cur.frz = 1'b0;
        cur.e_cr = '0;
        tbl.push_back(cur);
        start("freeze  ");
        expect_issue(FU_LDST, AND, 14, regm[2], regm[10], 0, 0);
        cur.done = 3'b010;
        tbl.push_back(cur);
        credit_row("freeze  ", 3'b010);
        // speculative ALU flushed, younger LDST still issues
        start("flush   ");
        disp(FU_ALU, ADD, 15, 11, 0, 0, 0, 1, 11, 0);
        tbl.push_back(cur);
        start("flush   ");
        disp(FU_LDST, ADD, 12, 11, 2, 0, 0, 0, 11, 0);
        tbl.push_back(cur);
        start("flush   ");
        cur.bm = 1'b1;
        writeback(11);
        tbl.push_back(cur);
        credit_row("flush   ", 3'b001);
        start("flush   ");
        expect_issue(FU_LDST, ADD, 12, regm[11], regm[2], 0, 0);
        cur.done = 3'b010;
        tbl.push_back(cur);
        credit_row("flush   ", 3'b010);
        idle_row("flush   ");
    endtask

    // idles until dispatch holds the unit's credit
    task automatic wait_credit(input fu_e fu, output logic ok);
        ok = 1'b0;
        for (int n = 0; n < 20; n++) begin
            if (credits[fu] > 0) begin
                ok = 1'b1;
                return;
            end
            row = '0;
            chk_en = 1'b0;
            @(posedge CLK);
            #1;
        end
    endtask

    initial begin
        logic ok;
        row = '0;
        nRST = 1'b0;
        chk_en = 1'b0;
        timeouts = 0;
        credit_faults = 0;
        for (int i = 0; i < NUM_FU; i++) begin
            credits[i] = 1;
        end
        build_table();
        repeat (5) @(posedge CLK);
        #1 nRST = 1'b1;
        for (int k = 0; k < tbl.size(); k++) begin
            @(posedge CLK);
            #1;
            if (tbl[k].den) begin
                wait_credit(tbl[k].dfu, ok);
                if (!ok) begin
                    $display("timeout waiting for a credit on unit %0d", tbl[k].dfu);
                    timeouts++;
                    break;
                end
                credits[tbl[k].dfu]--;
            end
            row = tbl[k];
            chk_en = 1'b1;
        end
        @(posedge CLK);
        #1;
        row = '0;
        chk_en = 1'b0;
        repeat (3) @(posedge CLK);
        for (int i = 0; i < NUM_FU; i++) begin
            if (credits[i] != 1) begin
                $display("unit %0d ends holding %0d credits instead of 1", i, credits[i]);
                credit_faults++;
            end
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d credit faults",
                 chk_errors, timeouts, credit_faults);
        if (chk_errors + timeouts + credit_faults == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
hw/issue_pkg.sv
hw/fust_if.sv
hw/regfile.sv
hw/fust.sv
hw/issue_select.sv
hw/issue_stage.sv
tb/issue_checker.sv
tb/issue_tb.sv

/* Makefile */
# Verilator build and run for the issue stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= issue_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= sources.f
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
